/* include/jesd_rx_macros.svh */
`ifndef JESD_RX_MACROS_SVH
`define JESD_RX_MACROS_SVH

// lanes served by the register block, 1 to 8
`define JESD_RX_NUM_LANES 4

// register word addresses
`define JESD_RX_ADDR_BUF_SIZE 12'h010
`define JESD_RX_ADDR_BUF_CFG 12'h090
`define JESD_RX_ADDR_STATS_CTRL 12'h091
`define JESD_RX_ADDR_THRESHOLD 12'h092
`define JESD_RX_ADDR_CTRL_STATE 12'h0a0

// first lane window, eight words per lane
`define JESD_RX_LANE_BASE 12'h0c0

// elastic buffer size in octets
`define JESD_RX_BUF_SIZE 32'd256

// frame alignment error threshold after reset
`define JESD_RX_THRESHOLD_RESET 8'd4

`endif

/* src/jesd_rx_pkg.sv */
`default_nettype none

package jesd_rx_pkg;

  // processor bus widths
  typedef logic [11:0] up_addr_t;
  typedef logic [31:0] up_data_t;

  // lane window addressing
  typedef logic [2:0] lane_idx_t;
  typedef logic [2:0] lane_word_t;

  typedef enum logic [2:0] {
    sel_none,
    sel_buf_size,
    sel_buf_cfg,
    sel_stats_ctrl,
    sel_threshold,
    sel_ctrl_state,
    sel_lane
  } reg_sel_t;

  // wishbone classic master signals
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    up_addr_t adr;
    up_data_t dat_w;
  } wb_req_t;

  // one decoded access, valid for a single cycle
  typedef struct packed {
    logic rd;
    logic wr;
    reg_sel_t sel;
    lane_idx_t lane;
    lane_word_t word;
    up_data_t wdata;
  } up_req_t;

  typedef struct packed {
    logic [1:0] cgs_state;
    logic [2:0] emb_state;
    logic ifs_ready;
    logic [13:0] latency;
    logic [7:0] frame_align_err_cnt;
    logic [31:0] err_statistics_cnt;
  } lane_status_t;

  // ilas configuration word as delivered by the link
  typedef struct packed {
    logic valid;
    logic [1:0] addr;
    up_data_t data;
  } ilas_in_t;

  typedef struct packed {
    logic buffer_early_release;
    logic [7:0] buffer_delay;
    logic [6:0] err_statistics_mask;
    logic err_statistics_reset;
    logic [7:0] frame_align_err_threshold;
  } rx_cfg_t;

endpackage

`default_nettype wire

/* src/jesd_rx_wb_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "jesd_rx_macros.svh"

module jesd_rx_wb_decode import jesd_rx_pkg::*; (
  input logic up_clk,
  input logic up_reset,
  input wb_req_t wb,
  output logic ack,
  output up_req_t req
);

  localparam up_addr_t lane_base = `JESD_RX_LANE_BASE;
  localparam logic [8:0] num_lanes = 9'(`JESD_RX_NUM_LANES);

  logic start;
  logic [8:0] blk;
  logic [8:0] lane_off;
  logic in_window;

  // new access only while no ack is pending
  assign start = wb.cyc && wb.stb && !ack;

  // upper address bits pick the eight word block
  assign blk = wb.adr[11:3];
  assign lane_off = blk - lane_base[11:3];
  assign in_window = (blk >= lane_base[11:3]) && (lane_off < num_lanes);

  always_comb begin
    req.rd = start && !wb.we;
    req.wr = start && wb.we;
    req.lane = lane_off[2:0];
    req.word = wb.adr[2:0];
    req.wdata = wb.dat_w;
    case (wb.adr)
      `JESD_RX_ADDR_BUF_SIZE: begin
        req.sel = sel_buf_size;
      end
      `JESD_RX_ADDR_BUF_CFG: begin
        req.sel = sel_buf_cfg;
      end
      `JESD_RX_ADDR_STATS_CTRL: begin
        req.sel = sel_stats_ctrl;
      end
      `JESD_RX_ADDR_THRESHOLD: begin
        req.sel = sel_threshold;
      end
      `JESD_RX_ADDR_CTRL_STATE: begin
        req.sel = sel_ctrl_state;
      end
      default: begin
        // lanes above the lane count fall through to none
        req.sel = in_window ? sel_lane : sel_none;
      end
    endcase
  end

  // ack follows the issue edge by one cycle
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      ack <= 1'b0;
    end else begin
      ack <= start;
    end
  end

endmodule

`default_nettype wire

/* src/jesd_rx_cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "jesd_rx_macros.svh"

module jesd_rx_cfg_regs import jesd_rx_pkg::*; (
  input logic up_clk,
  input logic up_reset,
  input up_req_t req,
  input logic cfg_is_writeable,
  output rx_cfg_t cfg
);

  logic wr_buf_cfg;
  logic wr_stats_ctrl;
  logic wr_threshold;

  // buffer config is locked while the link runs
  assign wr_buf_cfg = req.wr && (req.sel == sel_buf_cfg) && cfg_is_writeable;
  assign wr_stats_ctrl = req.wr && (req.sel == sel_stats_ctrl);
  assign wr_threshold = req.wr && (req.sel == sel_threshold);

  // elastic buffer release
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      cfg.buffer_early_release <= 1'b0;
      cfg.buffer_delay <= 8'd0;
    end else if (wr_buf_cfg) begin
      cfg.buffer_early_release <= req.wdata[16];
      // bits 1:0 are data path alignment, not stored
      cfg.buffer_delay <= req.wdata[9:2];
    end
  end

  // error statistics mask and counter reset
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      cfg.err_statistics_mask <= 7'd0;
      cfg.err_statistics_reset <= 1'b0;
    end else if (wr_stats_ctrl) begin
      cfg.err_statistics_mask <= req.wdata[14:8];
      cfg.err_statistics_reset <= req.wdata[0];
    end
  end

  // frame alignment error threshold
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      cfg.frame_align_err_threshold <= `JESD_RX_THRESHOLD_RESET;
    end else if (wr_threshold) begin
      cfg.frame_align_err_threshold <= req.wdata[7:0];
    end
  end

endmodule

`default_nettype wire

/* src/jesd_rx_lane_status.sv */
`timescale 1ns/10ps
`default_nettype none

module jesd_rx_lane_status import jesd_rx_pkg::*; (
  input logic up_clk,
  input logic up_reset,
  input lane_status_t status,
  input ilas_in_t ilas,
  input lane_word_t word,
  output up_data_t rdata
);

  // four ilas config words per lane
  up_data_t ilas_mem [4];

  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      for (int i = 0; i < 4; i++) begin
        ilas_mem[i] <= '0;
      end
    end else if (ilas.valid) begin
      ilas_mem[ilas.addr] <= ilas.data;
    end
  end

  // lane window: status in words 0-3, ilas in words 4-7
  always_comb begin
    case (word)
      3'd0: begin
        rdata = {26'd0, status.ifs_ready, status.emb_state, status.cgs_state};
      end
      3'd1: begin
        rdata = {18'd0, status.latency};
      end
      3'd2: begin
        rdata = status.err_statistics_cnt;
      end
      3'd3: begin
        rdata = {24'd0, status.frame_align_err_cnt};
      end
      default: begin
        rdata = ilas_mem[word[1:0]];
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/jesd_rx_read_mux.sv */
`timescale 1ns/10ps
`default_nettype none

`include "jesd_rx_macros.svh"

module jesd_rx_read_mux import jesd_rx_pkg::*; (
  input logic up_clk,
  input logic up_reset,
  input up_req_t req,
  input rx_cfg_t cfg,
  input logic [1:0] ctrl_state,
  input up_data_t lane_rdata [`JESD_RX_NUM_LANES],
  output up_data_t dat_r
);

  up_data_t lane_word;
  up_data_t rd_word;

  // pick the addressed lane, decoder keeps lane in range
  always_comb begin
    lane_word = '0;
    for (int i = 0; i < `JESD_RX_NUM_LANES; i++) begin
      if (req.lane == lane_idx_t'(i)) begin
        lane_word = lane_rdata[i];
      end
    end
  end

  always_comb begin
    case (req.sel)
      sel_buf_size: begin
        rd_word = `JESD_RX_BUF_SIZE;
      end
      sel_buf_cfg: begin
        rd_word = {15'd0, cfg.buffer_early_release, 6'd0, cfg.buffer_delay, 2'd0};
      end
      sel_stats_ctrl: begin
        rd_word = {17'd0, cfg.err_statistics_mask, 7'd0, cfg.err_statistics_reset};
      end
      sel_threshold: begin
        rd_word = {24'd0, cfg.frame_align_err_threshold};
      end
      sel_ctrl_state: begin
        rd_word = {30'd0, ctrl_state};
      end
      sel_lane: begin
        rd_word = lane_word;
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  // registered on the issue edge so it lines up with ack
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      dat_r <= '0;
    end else if (req.rd) begin
      dat_r <= rd_word;
    end
  end

endmodule

`default_nettype wire

/* src/jesd_rx_up.sv */
`timescale 1ns/10ps
`default_nettype none

`include "jesd_rx_macros.svh"

module jesd_rx_up import jesd_rx_pkg::*; (
  input logic up_clk,
  input logic up_reset,
  input wb_req_t wb,
  output logic ack,
  output up_data_t dat_r,
  input logic cfg_is_writeable,
  input logic [1:0] ctrl_state,
  input lane_status_t lane_status [`JESD_RX_NUM_LANES],
  input ilas_in_t ilas [`JESD_RX_NUM_LANES],
  output rx_cfg_t cfg
);

  up_req_t req;
  up_data_t lane_rdata [`JESD_RX_NUM_LANES];

  jesd_rx_wb_decode decode_i (
    .up_clk(up_clk),
    .up_reset(up_reset),
    .wb(wb),
    .ack(ack),
    .req(req)
  );

  jesd_rx_cfg_regs cfg_regs_i (
    .up_clk(up_clk),
    .up_reset(up_reset),
    .req(req),
    .cfg_is_writeable(cfg_is_writeable),
    .cfg(cfg)
  );

  // one status window per lane
  for (genvar i = 0; i < `JESD_RX_NUM_LANES; i++) begin : gen_lane
    jesd_rx_lane_status lane_status_i (
      .up_clk(up_clk),
      .up_reset(up_reset),
      .status(lane_status[i]),
      .ilas(ilas[i]),
      .word(req.word),
      .rdata(lane_rdata[i])
    );
  end

  jesd_rx_read_mux read_mux_i (
    .up_clk(up_clk),
    .up_reset(up_reset),
    .req(req),
    .cfg(cfg),
    .ctrl_state(ctrl_state),
    .lane_rdata(lane_rdata),
    .dat_r(dat_r)
  );

endmodule

`default_nettype wire

/* testbench/jesd_rx_up_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module jesd_rx_up_sva import jesd_rx_pkg::*; (
  input logic up_clk,
  input logic up_reset,
  input wb_req_t wb,
  input logic ack
);

  // ack answers an active strobe only
  ack_needs_strobe: assert property (
    @(posedge up_clk) disable iff (up_reset) ack |-> (wb.cyc && wb.stb)
  ) else $error("ack raised without cyc and stb");

  // single cycle acknowledge
  ack_one_cycle: assert property (
    @(posedge up_clk) disable iff (up_reset) ack |=> !ack
  ) else $error("ack held high for two cycles");

  ack_low_in_reset: assert property (
    @(posedge up_clk) up_reset |=> !ack
  ) else $error("ack high while reset is applied");

endmodule

`default_nettype wire

/* testbench/jesd_rx_up_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "jesd_rx_macros.svh"

module jesd_rx_up_tb import jesd_rx_pkg::*; ();

  localparam int num_lanes = `JESD_RX_NUM_LANES;
  localparam int num_access = 400;
  localparam int clk_period = 100;

  logic up_clk;
  logic up_reset;
  wb_req_t wb;
  logic ack;
  up_data_t dat_r;
  logic cfg_is_writeable;
  logic [1:0] ctrl_state;
  lane_status_t lane_status [num_lanes];
  ilas_in_t ilas [num_lanes];
  rx_cfg_t cfg;

  // reference state
  rx_cfg_t model_cfg;
  up_data_t model_ilas [num_lanes][4];
  logic [31:0] rng_state;
  int checks;
  int errors;

  jesd_rx_up jesd_rx_up_i (
    .up_clk(up_clk),
    .up_reset(up_reset),
    .wb(wb),
    .ack(ack),
    .dat_r(dat_r),
    .cfg_is_writeable(cfg_is_writeable),
    .ctrl_state(ctrl_state),
    .lane_status(lane_status),
    .ilas(ilas),
    .cfg(cfg)
  );

  bind jesd_rx_up jesd_rx_up_sva sva_i (
    .up_clk(up_clk),
    .up_reset(up_reset),
    .wb(wb),
    .ack(ack)
  );

  initial begin
    up_clk = 1'b0;
    forever begin
      #(clk_period / 2) up_clk = ~up_clk;
    end
  end

  // four cycles per access plus slack
  initial begin
    #((num_access * 4 + 200) * clk_period);
    $display("timeout: run did not complete in the expected number of cycles");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic up_addr_t pick_addr();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0: return `JESD_RX_ADDR_BUF_SIZE;
      3'd1: return `JESD_RX_ADDR_BUF_CFG;
      3'd2: return `JESD_RX_ADDR_STATS_CTRL;
      3'd3: return `JESD_RX_ADDR_THRESHOLD;
      3'd4: return `JESD_RX_ADDR_CTRL_STATE;
      3'd5, 3'd6: begin
        return 12'(32'h0c0 + 8 * (int'(r[10:8]) % num_lanes) + int'(r[13:11]));
      end
      default: begin
        if (r[3]) begin
          return r[31:20];
        end
        // windows of lanes that do not exist
        return 12'(32'h0c0 + 8 * (num_lanes + int'(r[10:8]) % (9 - num_lanes))
                   + int'(r[13:11]));
      end
    endcase
  endfunction

  function automatic up_data_t expect_read(input up_addr_t addr);
    int a;
    int lane;
    int w;
    lane_status_t st;
    up_data_t v;
    a = 32'(addr);
    v = '0;
    if (addr == 12'h010) begin
      v = 32'd256;
    end else if (addr == 12'h090) begin
      v = (32'(model_cfg.buffer_early_release) << 16) | (32'(model_cfg.buffer_delay) << 2);
    end else if (addr == 12'h091) begin
      v = (32'(model_cfg.err_statistics_mask) << 8) | 32'(model_cfg.err_statistics_reset);
    end else if (addr == 12'h092) begin
      v = 32'(model_cfg.frame_align_err_threshold);
    end else if (addr == 12'h0a0) begin
      v = 32'(ctrl_state);
    end else if (a >= 32'h0c0 && a < 32'h0c0 + 8 * num_lanes) begin
      lane = (a - 32'h0c0) / 8;
      w = a % 8;
      st = lane_status[lane];
      case (w)
        0: v = 32'(st.cgs_state) | (32'(st.emb_state) << 2) | (32'(st.ifs_ready) << 5);
        1: v = 32'(st.latency);
        2: v = st.err_statistics_cnt;
        3: v = 32'(st.frame_align_err_cnt);
        default: v = model_ilas[lane][w - 4];
      endcase
    end
    return v;
  endfunction

  task automatic model_write(input up_addr_t addr, input up_data_t d);
    if (addr == 12'h090 && cfg_is_writeable) begin
      model_cfg.buffer_early_release = d[16];
      model_cfg.buffer_delay = d[9:2];
    end else if (addr == 12'h091) begin
      model_cfg.err_statistics_mask = d[14:8];
      model_cfg.err_statistics_reset = d[0];
    end else if (addr == 12'h092) begin
      model_cfg.frame_align_err_threshold = d[7:0];
    end
  endtask

  // status, lock and ilas pulses change only between bus cycles
  task automatic shuffle_inputs();
    logic [31:0] r;
    logic [63:0] r64;
    up_data_t d;
    r = next_rand();
    cfg_is_writeable <= r[0];
    ctrl_state <= r[2:1];
    for (int i = 0; i < num_lanes; i++) begin
      r64 = {next_rand(), next_rand()};
      lane_status[i] <= r64[59:0];
      r = next_rand();
      d = next_rand();
      if (r[2:0] == 3'd0) begin
        ilas[i] <= '{valid: 1'b1, addr: r[4:3], data: d};
        model_ilas[i][r[4:3]] = d;
      end
    end
  endtask

  task automatic bus_access(input logic we, input up_addr_t addr, input up_data_t d);
    up_data_t expected;
    int waited;
    @(posedge up_clk);
    shuffle_inputs();
    @(posedge up_clk);
    for (int i = 0; i < num_lanes; i++) begin
      ilas[i].valid <= 1'b0;
    end
    wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat_w: d};
    // first negedge precedes the issue edge, ack belongs to the second
    waited = 0;
    do begin
      @(negedge up_clk);
      waited++;
    end while (!ack && waited < 8);
    checks++;
    assert (ack && waited == 2) else begin
      errors++;
      $display("%0t: acknowledge for address %h not one cycle after strobe", $time, addr);
    end
    if (ack) begin
      if (we) begin
        model_write(addr, d);
      end else begin
        expected = expect_read(addr);
        checks++;
        assert (dat_r === expected) else begin
          errors++;
          $display("MISMATCH at %0t: read of %h gave %h, expected %h",
                   $time, addr, dat_r, expected);
        end
      end
      checks++;
      assert (cfg === model_cfg) else begin
        errors++;
        $display("MISMATCH at %0t: cfg outputs %h, expected %h", $time, cfg, model_cfg);
      end
    end
    @(posedge up_clk);
    wb <= '0;
  endtask

  initial begin
    logic [31:0] r;
    up_addr_t addr;
    rng_state = 32'h5c63_ab6a;
    checks = 0;
    errors = 0;
    up_reset = 1'b1;
    wb = '0;
    cfg_is_writeable = 1'b0;
    ctrl_state = 2'd0;
    model_cfg = '0;
    model_cfg.frame_align_err_threshold = 8'd4;
    for (int i = 0; i < num_lanes; i++) begin
      lane_status[i] = '0;
      ilas[i] = '0;
      for (int j = 0; j < 4; j++) begin
        model_ilas[i][j] = '0;
      end
    end
    repeat (2) @(posedge up_clk);
    up_reset <= 1'b0;
    @(negedge up_clk);
    checks++;
    assert (cfg === model_cfg) else begin
      errors++;
      $display("MISMATCH at %0t: cfg after reset %h, expected %h", $time, cfg, model_cfg);
    end
    // reset values seen over the bus
    bus_access(1'b0, `JESD_RX_ADDR_BUF_SIZE, '0);
    bus_access(1'b0, `JESD_RX_ADDR_BUF_CFG, '0);
    bus_access(1'b0, `JESD_RX_ADDR_STATS_CTRL, '0);
    bus_access(1'b0, `JESD_RX_ADDR_THRESHOLD, '0);
    for (int n = 0; n < num_access; n++) begin
      addr = pick_addr();
      r = next_rand();
      bus_access(r[0], addr, next_rand());
    end
    @(posedge up_clk);
    $display("accesses %0d, checks %0d, errors %0d", num_access + 4, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
src/jesd_rx_pkg.sv
src/jesd_rx_wb_decode.sv
src/jesd_rx_cfg_regs.sv
src/jesd_rx_lane_status.sv
src/jesd_rx_read_mux.sv
src/jesd_rx_up.sv
testbench/jesd_rx_up_sva.sv
testbench/jesd_rx_up_tb.sv

/* Makefile */
TOP = jesd_rx_up_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
